// ==== hdl/ex_pkg.sv ====
`default_nettype none

package ex_pkg;

    localparam int NB_DATA     = 32;
    localparam int NB_REG      = 5;
    localparam int NB_ALU_OP   = 6;
    localparam int NB_ALU_CTRL = 4;
    localparam int NB_FCODE    = 6;

    // Main-decoder operation classes as MIPS opcode values
    localparam logic [NB_ALU_OP-1:0] OP_RTYPE  = 6'b000000;
    localparam logic [NB_ALU_OP-1:0] OP_ADDI   = 6'b001000;
    localparam logic [NB_ALU_OP-1:0] OP_ANDI   = 6'b001100;
    localparam logic [NB_ALU_OP-1:0] OP_ORI    = 6'b001101;
    localparam logic [NB_ALU_OP-1:0] OP_XORI   = 6'b001110;
    localparam logic [NB_ALU_OP-1:0] OP_LUI    = 6'b001111;
    localparam logic [NB_ALU_OP-1:0] OP_SLTI   = 6'b001010;
    localparam logic [NB_ALU_OP-1:0] OP_BRANCH = 6'b000100;  // beq/bne compare
    localparam logic [NB_ALU_OP-1:0] OP_JAL    = 6'b000011;

    localparam logic [NB_ALU_CTRL-1:0] ALU_ADD  = 4'd0;
    localparam logic [NB_ALU_CTRL-1:0] ALU_SUB  = 4'd1;
    localparam logic [NB_ALU_CTRL-1:0] ALU_AND  = 4'd2;
    localparam logic [NB_ALU_CTRL-1:0] ALU_OR   = 4'd3;
    localparam logic [NB_ALU_CTRL-1:0] ALU_XOR  = 4'd4;
    localparam logic [NB_ALU_CTRL-1:0] ALU_NOR  = 4'd5;
    localparam logic [NB_ALU_CTRL-1:0] ALU_SLT  = 4'd6;
    localparam logic [NB_ALU_CTRL-1:0] ALU_SLTU = 4'd7;
    localparam logic [NB_ALU_CTRL-1:0] ALU_SLL  = 4'd8;
    localparam logic [NB_ALU_CTRL-1:0] ALU_SRL  = 4'd9;
    localparam logic [NB_ALU_CTRL-1:0] ALU_SRA  = 4'd10;
    localparam logic [NB_ALU_CTRL-1:0] ALU_LUI  = 4'd11;

    localparam logic [NB_FCODE-1:0] FN_SLL  = 6'b000000;
    localparam logic [NB_FCODE-1:0] FN_SRL  = 6'b000010;
    localparam logic [NB_FCODE-1:0] FN_SRA  = 6'b000011;
    localparam logic [NB_FCODE-1:0] FN_SLLV = 6'b000100;
    localparam logic [NB_FCODE-1:0] FN_SRLV = 6'b000110;
    localparam logic [NB_FCODE-1:0] FN_SRAV = 6'b000111;
    localparam logic [NB_FCODE-1:0] FN_ADD  = 6'b100000;
    localparam logic [NB_FCODE-1:0] FN_ADDU = 6'b100001;
    localparam logic [NB_FCODE-1:0] FN_SUB  = 6'b100010;
    localparam logic [NB_FCODE-1:0] FN_SUBU = 6'b100011;
    localparam logic [NB_FCODE-1:0] FN_AND  = 6'b100100;
    localparam logic [NB_FCODE-1:0] FN_OR   = 6'b100101;
    localparam logic [NB_FCODE-1:0] FN_XOR  = 6'b100110;
    localparam logic [NB_FCODE-1:0] FN_NOR  = 6'b100111;
    localparam logic [NB_FCODE-1:0] FN_SLT  = 6'b101010;
    localparam logic [NB_FCODE-1:0] FN_SLTU = 6'b101011;

    typedef struct packed {
        logic [15:0]         sext;   // Sign bits of the 16-bit field
        logic [NB_REG-1:0]   rd;
        logic [NB_REG-1:0]   shamt;
        logic [NB_FCODE-1:0] funct;
    } imm_rtype_t;

    // One word in arithmetic or R-type view
    typedef union packed {
        logic [NB_DATA-1:0] word;
        imm_rtype_t         r;
    } imm_word_u;

endpackage

`default_nettype wire

// ==== hdl/id_ex_reg.sv ====
`default_nettype none

module id_ex_reg #(
    parameter int NB_DATA = ex_pkg::NB_DATA,
    parameter int NB_REG  = ex_pkg::NB_REG
) (
    input  wire                           i_clock,
    input  wire                           i_reset,
    input  wire                           i_stall,   // Hold current instruction
    input  wire                           i_flush,   // Capture a bubble
    input  wire                           i_reg_write, i_mem_to_reg, i_mem_read, i_mem_write,
    input  wire                           i_branch, i_alu_src, i_reg_dest,
    input  wire                           i_byte_en, i_halfword_en, i_word_en, i_hlt,
    input  wire [ex_pkg::NB_ALU_OP-1:0]   i_alu_op,
    input  wire [NB_DATA-1:0]             i_pc, i_data_a, i_data_b, i_immediate,
    input  wire [NB_REG-1:0]              i_rt,
    output logic                          o_reg_write, o_mem_to_reg, o_mem_read, o_mem_write,
    output logic                          o_branch, o_alu_src, o_reg_dest,
    output logic                          o_byte_en, o_halfword_en, o_word_en, o_hlt,
    output logic [ex_pkg::NB_ALU_OP-1:0]  o_alu_op,
    output logic [NB_DATA-1:0]            o_pc, o_data_a, o_data_b, o_immediate,
    output logic [NB_REG-1:0]             o_rt
);
    import ex_pkg::*;

    localparam int NB_WORD = 11 + NB_ALU_OP + 4 * NB_DATA + NB_REG;

    logic [NB_WORD-1:0] next_word;
    logic [NB_WORD-1:0] word_q;

    assign next_word = {i_reg_write, i_mem_to_reg, i_mem_read, i_mem_write, i_branch,
                        i_alu_src, i_reg_dest, i_byte_en, i_halfword_en, i_word_en, i_hlt,
                        i_alu_op, i_pc, i_data_a, i_data_b, i_immediate, i_rt};

    always_ff @(posedge i_clock) begin
        if (i_reset || i_flush) begin
            word_q <= '0;   // Flush beats stall
        end else if (!i_stall) begin
            word_q <= next_word;
        end
    end

    assign {o_reg_write, o_mem_to_reg, o_mem_read, o_mem_write, o_branch,
            o_alu_src, o_reg_dest, o_byte_en, o_halfword_en, o_word_en, o_hlt,
            o_alu_op, o_pc, o_data_a, o_data_b, o_immediate, o_rt} = word_q;

endmodule

`default_nettype wire

// ==== hdl/alu_control.sv ====
`default_nettype none

module alu_control (
    input  wire [ex_pkg::NB_ALU_OP-1:0]     i_alu_op,
    input  wire [ex_pkg::NB_FCODE-1:0]      i_funct_code,
    output logic [ex_pkg::NB_ALU_CTRL-1:0]  o_alu_ctrl,
    output logic                            o_shamt_ctrl,   // Amount from shamt field
    output logic                            o_r31_ctrl      // jal links to r31
);
    import ex_pkg::*;

    logic [NB_ALU_CTRL-1:0] rtype_ctrl;

    always_comb begin
        case (i_funct_code)
            FN_ADD, FN_ADDU: rtype_ctrl = ALU_ADD;
            FN_SUB, FN_SUBU: rtype_ctrl = ALU_SUB;
            FN_AND:          rtype_ctrl = ALU_AND;
            FN_OR:           rtype_ctrl = ALU_OR;
            FN_XOR:          rtype_ctrl = ALU_XOR;
            FN_NOR:          rtype_ctrl = ALU_NOR;
            FN_SLT:          rtype_ctrl = ALU_SLT;
            FN_SLTU:         rtype_ctrl = ALU_SLTU;
            FN_SLL, FN_SLLV: rtype_ctrl = ALU_SLL;   // Only operand A differs
            FN_SRL, FN_SRLV: rtype_ctrl = ALU_SRL;
            FN_SRA, FN_SRAV: rtype_ctrl = ALU_SRA;
            default:         rtype_ctrl = ALU_ADD;
        endcase
    end

    always_comb begin
        case (i_alu_op)
            OP_RTYPE:  o_alu_ctrl = rtype_ctrl;
            OP_ADDI:   o_alu_ctrl = ALU_ADD;
            OP_ANDI:   o_alu_ctrl = ALU_AND;
            OP_ORI:    o_alu_ctrl = ALU_OR;
            OP_XORI:   o_alu_ctrl = ALU_XOR;
            OP_LUI:    o_alu_ctrl = ALU_LUI;
            OP_SLTI:   o_alu_ctrl = ALU_SLT;
            OP_BRANCH: o_alu_ctrl = ALU_SUB;   // Equal gives zero
            default:   o_alu_ctrl = ALU_ADD;   // jal included
        endcase
    end

    assign o_shamt_ctrl = (i_alu_op == OP_RTYPE) &&
                          (i_funct_code == FN_SLL || i_funct_code == FN_SRL ||
                           i_funct_code == FN_SRA);

    assign o_r31_ctrl = (i_alu_op == OP_JAL);

endmodule

`default_nettype wire

// ==== hdl/alu.sv ====
`default_nettype none

module alu #(
    parameter int NB_DATA = ex_pkg::NB_DATA
) (
    input  wire [NB_DATA-1:0]               i_a,
    input  wire [NB_DATA-1:0]               i_b,
    input  wire [ex_pkg::NB_ALU_CTRL-1:0]   i_alu_ctrl,
    output logic [NB_DATA-1:0]              o_result,
    output logic                            o_zero
);
    import ex_pkg::*;

    logic [4:0] shift;

    assign shift = i_a[4:0];   // Shift amount in low bits of A

    always_comb begin
        case (i_alu_ctrl)
            ALU_ADD:  o_result = i_a + i_b;
            ALU_SUB:  o_result = i_a - i_b;
            ALU_AND:  o_result = i_a & i_b;
            ALU_OR:   o_result = i_a | i_b;
            ALU_XOR:  o_result = i_a ^ i_b;
            ALU_NOR:  o_result = ~(i_a | i_b);
            ALU_SLT:  o_result = {{(NB_DATA-1){1'b0}}, $signed(i_a) < $signed(i_b)};
            ALU_SLTU: o_result = {{(NB_DATA-1){1'b0}}, i_a < i_b};
            ALU_SLL:  o_result = i_b << shift;
            ALU_SRL:  o_result = i_b >> shift;
            ALU_SRA:  o_result = $signed(i_b) >>> shift;
            ALU_LUI:  o_result = {i_b[NB_DATA/2-1:0], {(NB_DATA/2){1'b0}}};
            default:  o_result = '0;
        endcase
    end

    assign o_zero = (o_result == '0);

endmodule

`default_nettype wire

// ==== hdl/ex_stage.sv ====
`default_nettype none

module ex_stage #(
    parameter int NB_DATA = ex_pkg::NB_DATA,
    parameter int NB_REG  = ex_pkg::NB_REG
) (
    input  wire                         i_reg_write, i_mem_to_reg, i_mem_read, i_mem_write,
    input  wire                         i_branch, i_alu_src, i_reg_dest,
    input  wire                         i_byte_en, i_halfword_en, i_word_en, i_hlt,
    input  wire [ex_pkg::NB_ALU_OP-1:0] i_alu_op,
    input  wire [NB_DATA-1:0]           i_pc, i_data_a, i_data_b, i_immediate,
    input  wire [NB_REG-1:0]            i_rt,
    output logic                        o_reg_write, o_mem_to_reg, o_mem_read, o_mem_write,
    output logic                        o_branch, o_zero, o_r31_ctrl, o_hlt,
    output logic                        o_byte_en, o_halfword_en, o_word_en,
    output logic [NB_DATA-1:0]          o_branch_addr, o_alu_result, o_data_b, o_pc,
    output logic [NB_REG-1:0]           o_selected_reg
);
    import ex_pkg::*;

    imm_word_u              imm;
    logic [NB_ALU_CTRL-1:0] alu_ctrl;
    logic                   shamt_ctrl;
    logic [NB_DATA-1:0]     alu_a;
    logic [NB_DATA-1:0]     alu_b;
    logic [NB_REG-1:0]      rt_rd;

    assign imm = i_immediate;

    alu_control alu_control_1 (
        .i_alu_op     (i_alu_op),
        .i_funct_code (imm.r.funct),
        .o_alu_ctrl   (alu_ctrl),
        .o_shamt_ctrl (shamt_ctrl),
        .o_r31_ctrl   (o_r31_ctrl)
    );

    alu #(
        .NB_DATA (NB_DATA)
    ) alu_1 (
        .i_a        (alu_a),
        .i_b        (alu_b),
        .i_alu_ctrl (alu_ctrl),
        .o_result   (o_alu_result),
        .o_zero     (o_zero)
    );

    // Constant shifts take the amount from the instruction word
    assign alu_a = shamt_ctrl ? {{(NB_DATA-NB_REG){1'b0}}, imm.r.shamt} : i_data_a;
    assign alu_b = i_alu_src ? imm.word : i_data_b;

    assign rt_rd          = i_reg_dest ? imm.r.rd : i_rt;
    assign o_selected_reg = o_r31_ctrl ? NB_REG'(31) : rt_rd;

    assign o_branch_addr = i_pc + (imm.word << 2);   // PC is already PC+4

    assign o_reg_write   = i_reg_write;
    assign o_mem_to_reg  = i_mem_to_reg;
    assign o_mem_read    = i_mem_read;
    assign o_mem_write   = i_mem_write;
    assign o_branch      = i_branch;
    assign o_data_b      = i_data_b;     // Store data
    assign o_byte_en     = i_byte_en;
    assign o_halfword_en = i_halfword_en;
    assign o_word_en     = i_word_en;
    assign o_pc          = i_pc;
    assign o_hlt         = i_hlt;

endmodule

`default_nettype wire

// ==== hdl/ex_mem_reg.sv ====
`default_nettype none

module ex_mem_reg #(
    parameter int NB_DATA = ex_pkg::NB_DATA,
    parameter int NB_REG  = ex_pkg::NB_REG
) (
    input  wire                 i_clock,
    input  wire                 i_reset,
    input  wire                 i_reg_write, i_mem_to_reg, i_mem_read, i_mem_write,
    input  wire                 i_branch, i_zero, i_r31_ctrl, i_hlt,
    input  wire                 i_byte_en, i_halfword_en, i_word_en,
    input  wire [NB_DATA-1:0]   i_branch_addr, i_alu_result, i_data_b, i_pc,
    input  wire [NB_REG-1:0]    i_selected_reg,
    output logic                o_reg_write, o_mem_to_reg, o_mem_read, o_mem_write,
    output logic                o_branch, o_zero, o_r31_ctrl, o_hlt,
    output logic                o_byte_en, o_halfword_en, o_word_en,
    output logic [NB_DATA-1:0]  o_branch_addr, o_alu_result, o_data_b, o_pc,
    output logic [NB_REG-1:0]   o_selected_reg
);
    localparam int NB_WORD = 11 + 4 * NB_DATA + NB_REG;

    logic [NB_WORD-1:0] next_word;
    logic [NB_WORD-1:0] word_q;

    assign next_word = {i_reg_write, i_mem_to_reg, i_mem_read, i_mem_write, i_branch,
                        i_zero, i_r31_ctrl, i_hlt, i_byte_en, i_halfword_en, i_word_en,
                        i_branch_addr, i_alu_result, i_data_b, i_pc, i_selected_reg};

    // A held ID/EX instruction simply repeats here
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            word_q <= '0;
        end else begin
            word_q <= next_word;
        end
    end

    assign {o_reg_write, o_mem_to_reg, o_mem_read, o_mem_write, o_branch,
            o_zero, o_r31_ctrl, o_hlt, o_byte_en, o_halfword_en, o_word_en,
            o_branch_addr, o_alu_result, o_data_b, o_pc, o_selected_reg} = word_q;

endmodule

`default_nettype wire

// ==== hdl/ex_pipe_top.sv ====
`default_nettype none

module ex_pipe_top #(
    parameter int NB_DATA = ex_pkg::NB_DATA,
    parameter int NB_REG  = ex_pkg::NB_REG
) (
    input  wire                         i_clock,
    input  wire                         i_reset,
    input  wire                         i_stall,
    input  wire                         i_flush,
    input  wire                         i_reg_write, i_mem_to_reg, i_mem_read, i_mem_write,
    input  wire                         i_branch, i_alu_src, i_reg_dest,
    input  wire                         i_byte_en, i_halfword_en, i_word_en, i_hlt,
    input  wire [ex_pkg::NB_ALU_OP-1:0] i_alu_op,
    input  wire [NB_DATA-1:0]           i_pc, i_data_a, i_data_b, i_immediate,
    input  wire [NB_REG-1:0]            i_rt,
    output wire                         o_reg_write, o_mem_to_reg, o_mem_read, o_mem_write,
    output wire                         o_branch, o_zero, o_r31_ctrl, o_hlt,
    output wire                         o_byte_en, o_halfword_en, o_word_en,
    output wire [NB_DATA-1:0]           o_branch_addr, o_alu_result, o_data_b, o_pc,
    output wire [NB_REG-1:0]            o_selected_reg
);
    import ex_pkg::*;

    wire                 id_reg_write, id_mem_to_reg, id_mem_read, id_mem_write;
    wire                 id_branch, id_alu_src, id_reg_dest;
    wire                 id_byte_en, id_halfword_en, id_word_en, id_hlt;
    wire [NB_ALU_OP-1:0] id_alu_op;
    wire [NB_DATA-1:0]   id_pc, id_data_a, id_data_b, id_immediate;
    wire [NB_REG-1:0]    id_rt;

    wire                 ex_reg_write, ex_mem_to_reg, ex_mem_read, ex_mem_write;
    wire                 ex_branch, ex_zero, ex_r31_ctrl, ex_hlt;
    wire                 ex_byte_en, ex_halfword_en, ex_word_en;
    wire [NB_DATA-1:0]   ex_branch_addr, ex_alu_result, ex_data_b, ex_pc;
    wire [NB_REG-1:0]    ex_selected_reg;

    id_ex_reg #(
        .NB_DATA (NB_DATA),
        .NB_REG  (NB_REG)
    ) id_ex_reg_1 (
        .i_clock       (i_clock),        .i_reset       (i_reset),
        .i_stall       (i_stall),        .i_flush       (i_flush),
        .i_reg_write   (i_reg_write),    .i_mem_to_reg  (i_mem_to_reg),
        .i_mem_read    (i_mem_read),     .i_mem_write   (i_mem_write),
        .i_branch      (i_branch),       .i_alu_src     (i_alu_src),
        .i_reg_dest    (i_reg_dest),     .i_byte_en     (i_byte_en),
        .i_halfword_en (i_halfword_en),  .i_word_en     (i_word_en),
        .i_hlt         (i_hlt),          .i_alu_op      (i_alu_op),
        .i_pc          (i_pc),           .i_data_a      (i_data_a),
        .i_data_b      (i_data_b),       .i_immediate   (i_immediate),
        .i_rt          (i_rt),
        .o_reg_write   (id_reg_write),   .o_mem_to_reg  (id_mem_to_reg),
        .o_mem_read    (id_mem_read),    .o_mem_write   (id_mem_write),
        .o_branch      (id_branch),      .o_alu_src     (id_alu_src),
        .o_reg_dest    (id_reg_dest),    .o_byte_en     (id_byte_en),
        .o_halfword_en (id_halfword_en), .o_word_en     (id_word_en),
        .o_hlt         (id_hlt),         .o_alu_op      (id_alu_op),
        .o_pc          (id_pc),          .o_data_a      (id_data_a),
        .o_data_b      (id_data_b),      .o_immediate   (id_immediate),
        .o_rt          (id_rt)
    );

    ex_stage #(
        .NB_DATA (NB_DATA),
        .NB_REG  (NB_REG)
    ) ex_stage_1 (
        .i_reg_write   (id_reg_write),   .i_mem_to_reg  (id_mem_to_reg),
        .i_mem_read    (id_mem_read),    .i_mem_write   (id_mem_write),
        .i_branch      (id_branch),      .i_alu_src     (id_alu_src),
        .i_reg_dest    (id_reg_dest),    .i_byte_en     (id_byte_en),
        .i_halfword_en (id_halfword_en), .i_word_en     (id_word_en),
        .i_hlt         (id_hlt),         .i_alu_op      (id_alu_op),
        .i_pc          (id_pc),          .i_data_a      (id_data_a),
        .i_data_b      (id_data_b),      .i_immediate   (id_immediate),
        .i_rt          (id_rt),
        .o_reg_write   (ex_reg_write),   .o_mem_to_reg  (ex_mem_to_reg),
        .o_mem_read    (ex_mem_read),    .o_mem_write   (ex_mem_write),
        .o_branch      (ex_branch),      .o_zero        (ex_zero),
        .o_r31_ctrl    (ex_r31_ctrl),    .o_hlt         (ex_hlt),
        .o_byte_en     (ex_byte_en),     .o_halfword_en (ex_halfword_en),
        .o_word_en     (ex_word_en),     .o_branch_addr (ex_branch_addr),
        .o_alu_result  (ex_alu_result),  .o_data_b      (ex_data_b),
        .o_pc          (ex_pc),          .o_selected_reg(ex_selected_reg)
    );

    ex_mem_reg #(
        .NB_DATA (NB_DATA),
        .NB_REG  (NB_REG)
    ) ex_mem_reg_1 (
        .i_clock       (i_clock),        .i_reset       (i_reset),
        .i_reg_write   (ex_reg_write),   .i_mem_to_reg  (ex_mem_to_reg),
        .i_mem_read    (ex_mem_read),    .i_mem_write   (ex_mem_write),
        .i_branch      (ex_branch),      .i_zero        (ex_zero),
        .i_r31_ctrl    (ex_r31_ctrl),    .i_hlt         (ex_hlt),
        .i_byte_en     (ex_byte_en),     .i_halfword_en (ex_halfword_en),
        .i_word_en     (ex_word_en),     .i_branch_addr (ex_branch_addr),
        .i_alu_result  (ex_alu_result),  .i_data_b      (ex_data_b),
        .i_pc          (ex_pc),          .i_selected_reg(ex_selected_reg),
        .o_reg_write   (o_reg_write),    .o_mem_to_reg  (o_mem_to_reg),
        .o_mem_read    (o_mem_read),     .o_mem_write   (o_mem_write),
        .o_branch      (o_branch),       .o_zero        (o_zero),
        .o_r31_ctrl    (o_r31_ctrl),     .o_hlt         (o_hlt),
        .o_byte_en     (o_byte_en),      .o_halfword_en (o_halfword_en),
        .o_word_en     (o_word_en),      .o_branch_addr (o_branch_addr),
        .o_alu_result  (o_alu_result),   .o_data_b      (o_data_b),
        .o_pc          (o_pc),           .o_selected_reg(o_selected_reg)
    );

endmodule

`default_nettype wire

// ==== bench/ex_pipe_props.sv ====
`default_nettype none

module ex_pipe_props #(
    parameter int NB_DATA = ex_pkg::NB_DATA,
    parameter int NB_REG  = ex_pkg::NB_REG
) (
    input wire                i_clock,
    input wire                i_reset,
    input wire                i_zero,
    input wire                i_r31_ctrl,
    input wire [9:0]          i_flags,        // Control flags without zero
    input wire [NB_DATA-1:0]  i_alu_result,
    input wire [NB_REG-1:0]   i_selected_reg
);
    int fail_count = 0;   // Read by the testbench

    // The EX/MEM word is still the reset value one edge after reset
    assert property (@(posedge i_clock) disable iff (i_reset)
        !$past(i_reset) |-> (i_zero == (i_alu_result == '0)))
    else begin
        fail_count++;
        $error("zero flag disagrees with the ALU result");
    end

    assert property (@(posedge i_clock) disable iff (i_reset)
        i_r31_ctrl |-> (i_selected_reg == NB_REG'(31)))
    else begin
        fail_count++;
        $error("r31 control set but selected register is not 31");
    end

    assert property (@(posedge i_clock) i_reset |=> (i_flags == '0))
    else begin
        fail_count++;
        $error("a control flag is high one cycle after reset");
    end

endmodule

bind ex_pipe_top ex_pipe_props #(
    .NB_DATA (NB_DATA),
    .NB_REG  (NB_REG)
) props_i (
    .i_clock        (i_clock),
    .i_reset        (i_reset),
    .i_zero         (o_zero),
    .i_r31_ctrl     (o_r31_ctrl),
    .i_flags        ({o_reg_write, o_mem_to_reg, o_mem_read, o_mem_write, o_branch,
                      o_r31_ctrl, o_hlt, o_byte_en, o_halfword_en, o_word_en}),
    .i_alu_result   (o_alu_result),
    .i_selected_reg (o_selected_reg)
);

`default_nettype wire

// ==== bench/ex_pipe_tb.sv ====
`default_nettype none

module ex_pipe_tb;
    import ex_pkg::*;

    typedef struct packed {
        logic                 reg_write, mem_to_reg, mem_read, mem_write;
        logic                 branch, alu_src, reg_dest;
        logic                 byte_en, halfword_en, word_en, hlt;
        logic [NB_ALU_OP-1:0] alu_op;
        logic [NB_DATA-1:0]   pc, data_a, data_b, immediate;
        logic [NB_REG-1:0]    rt;
    } instr_t;

    typedef struct packed {
        logic               reg_write, mem_to_reg, mem_read, mem_write;
        logic               branch, zero, r31_ctrl, hlt;
        logic               byte_en, halfword_en, word_en;
        logic [NB_DATA-1:0] branch_addr, alu_result, data_b, pc;
        logic [NB_REG-1:0]  selected_reg;
    } result_t;

    localparam int N_RANDOM = 300;

    logic    clock = 1'b0;
    logic    reset;
    logic    stall;
    logic    flush;
    instr_t  drv;
    instr_t  held;            // Model of the ID/EX contents
    integer  seed = 32'h9261_3985;
    int      cycle = 0;
    int      errors = 0;
    int      timeouts = 0;
    int      due_q[$];
    result_t exp_q[$];

    logic [NB_FCODE-1:0] funct_list [16] = '{FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR,
        FN_XOR, FN_NOR, FN_SLT, FN_SLTU, FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV};
    logic [NB_ALU_OP-1:0] op_list [9] = '{OP_RTYPE, OP_ADDI, OP_ANDI, OP_ORI, OP_XORI,
        OP_LUI, OP_SLTI, OP_BRANCH, OP_JAL};

    wire                reg_write, mem_to_reg, mem_read, mem_write, branch, zero;
    wire                r31_ctrl, hlt, byte_en, halfword_en, word_en;
    wire [NB_DATA-1:0]  branch_addr, alu_result, data_b, pc;
    wire [NB_REG-1:0]   selected_reg;

    ex_pipe_top #(
        .NB_DATA (NB_DATA),
        .NB_REG  (NB_REG)
    ) dut_i (
        .i_clock (clock), .i_reset (reset), .i_stall (stall), .i_flush (flush),
        .i_reg_write (drv.reg_write), .i_mem_to_reg (drv.mem_to_reg),
        .i_mem_read (drv.mem_read), .i_mem_write (drv.mem_write), .i_branch (drv.branch),
        .i_alu_src (drv.alu_src), .i_reg_dest (drv.reg_dest), .i_byte_en (drv.byte_en),
        .i_halfword_en (drv.halfword_en), .i_word_en (drv.word_en), .i_hlt (drv.hlt),
        .i_alu_op (drv.alu_op), .i_pc (drv.pc), .i_data_a (drv.data_a),
        .i_data_b (drv.data_b), .i_immediate (drv.immediate), .i_rt (drv.rt),
        .o_reg_write (reg_write), .o_mem_to_reg (mem_to_reg), .o_mem_read (mem_read),
        .o_mem_write (mem_write), .o_branch (branch), .o_zero (zero),
        .o_r31_ctrl (r31_ctrl), .o_hlt (hlt), .o_byte_en (byte_en),
        .o_halfword_en (halfword_en), .o_word_en (word_en), .o_branch_addr (branch_addr),
        .o_alu_result (alu_result), .o_data_b (data_b), .o_pc (pc),
        .o_selected_reg (selected_reg)
    );

    always #4 clock = ~clock;

    always @(posedge clock) begin
        cycle <= cycle + 1;
    end

    // Expected EX/MEM outputs for one instruction held in ID/EX
    function automatic result_t model(input instr_t in);
        imm_word_u          imm;
        logic [NB_DATA-1:0] a;
        logic [NB_DATA-1:0] b;
        logic [NB_DATA-1:0] y;
        logic               eq_zero;
        logic               r31;
        logic [NB_REG-1:0]  sel;
        imm = in.immediate;
        a   = in.data_a;
        b   = in.alu_src ? in.immediate : in.data_b;
        case (in.alu_op)
            OP_RTYPE: begin
                case (imm.r.funct)
                    FN_SUB, FN_SUBU: y = a - b;
                    FN_AND:  y = a & b;
                    FN_OR:   y = a | b;
                    FN_XOR:  y = a ^ b;
                    FN_NOR:  y = ~(a | b);
                    FN_SLT:  y = ($signed(a) < $signed(b)) ? 1 : 0;
                    FN_SLTU: y = (a < b) ? 1 : 0;
                    FN_SLL:  y = b << imm.r.shamt;
                    FN_SRL:  y = b >> imm.r.shamt;
                    FN_SRA:  y = $signed(b) >>> imm.r.shamt;
                    FN_SLLV: y = b << a[4:0];
                    FN_SRLV: y = b >> a[4:0];
                    FN_SRAV: y = $signed(b) >>> a[4:0];
                    default: y = a + b;   // add, addu
                endcase
            end
            OP_ANDI:   y = a & b;
            OP_ORI:    y = a | b;
            OP_XORI:   y = a ^ b;
            OP_LUI:    y = {b[15:0], 16'h0000};
            OP_SLTI:   y = ($signed(a) < $signed(b)) ? 1 : 0;
            OP_BRANCH: y = a - b;
            default:   y = a + b;
        endcase
        eq_zero = (in.alu_op == OP_BRANCH) ? (a == b) : (y == '0);
        r31     = (in.alu_op == OP_JAL);
        sel     = r31 ? NB_REG'(31) : (in.reg_dest ? imm.r.rd : in.rt);
        return {in.reg_write, in.mem_to_reg, in.mem_read, in.mem_write, in.branch,
                eq_zero, r31, in.hlt, in.byte_en, in.halfword_en, in.word_en,
                in.pc + {imm.word[NB_DATA-3:0], 2'b00}, y, in.data_b, in.pc, sel};
    endfunction

    task automatic check_value(input string name, input logic [NB_DATA-1:0] expected,
                               input logic [NB_DATA-1:0] actual);
        assert (actual === expected)
        else begin
            errors++;
            $display("mismatch at %0t: %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic compare_outputs(input result_t e);
        check_value("o_reg_write", e.reg_write, reg_write);
        check_value("o_mem_to_reg", e.mem_to_reg, mem_to_reg);
        check_value("o_mem_read", e.mem_read, mem_read);
        check_value("o_mem_write", e.mem_write, mem_write);
        check_value("o_branch", e.branch, branch);
        check_value("o_zero", e.zero, zero);
        check_value("o_r31_ctrl", e.r31_ctrl, r31_ctrl);
        check_value("o_hlt", e.hlt, hlt);
        check_value("o_byte_en", e.byte_en, byte_en);
        check_value("o_halfword_en", e.halfword_en, halfword_en);
        check_value("o_word_en", e.word_en, word_en);
        check_value("o_branch_addr", e.branch_addr, branch_addr);
        check_value("o_alu_result", e.alu_result, alu_result);
        check_value("o_data_b", e.data_b, data_b);
        check_value("o_pc", e.pc, pc);
        check_value("o_selected_reg", e.selected_reg, selected_reg);
    endtask

    always @(negedge clock) begin   // Outputs settled mid-cycle
        if (due_q.size() > 0 && due_q[0] == cycle) begin
            compare_outputs(exp_q.pop_front());
            void'(due_q.pop_front());
        end
    end

    task automatic make_instr(input logic [NB_ALU_OP-1:0] op, input logic [NB_FCODE-1:0] fn,
                              output instr_t in);
        logic [31:0] r;
        logic [15:0] imm16;
        r = $random(seed);
        {in.reg_write, in.mem_to_reg, in.mem_read, in.mem_write, in.branch, in.alu_src,
         in.reg_dest, in.byte_en, in.halfword_en, in.word_en, in.hlt} = r[10:0];
        in.alu_op = op;
        in.pc     = {r[31:13], 13'h0} ^ $random(seed);
        in.pc[1:0] = 2'b00;
        in.data_a = $random(seed);
        in.data_b = (r[12:11] == 2'b00) ? in.data_a : $random(seed);   // Equal operands
        imm16     = 16'($random(seed));
        if (op == OP_RTYPE) begin
            imm16[5:0] = fn;
        end
        in.immediate = {{16{imm16[15]}}, imm16};
        in.rt        = NB_REG'($random(seed));
        case (op)
            OP_RTYPE: {in.alu_src, in.reg_dest} = 2'b01;
            OP_BRANCH: {in.alu_src, in.reg_dest, in.branch} = 3'b001;
            OP_JAL: in.reg_write = 1'b1;
            default: {in.alu_src, in.reg_dest} = 2'b10;
        endcase
    endtask

    // Called 1 unit after a rising edge and returns 1 unit after the next one
    task automatic drive_instr(input instr_t in, input logic do_stall, input logic do_flush);
        drv   = in;
        stall = do_stall;
        flush = do_flush;
        if (do_flush) begin
            held = '0;
        end else if (!do_stall) begin
            held = in;
        end
        due_q.push_back(cycle + 2);
        exp_q.push_back(model(held));   // Stall repeats the held entry
        @(posedge clock);
        #1;
    endtask

    initial begin
        instr_t      in;
        logic [31:0] r;
        int          wait_count;
        drv   = '0;
        held  = '0;
        stall = 1'b0;
        flush = 1'b0;
        reset = 1'b1;
        due_q.push_back(1);
        exp_q.push_back('0);
        due_q.push_back(2);
        exp_q.push_back('0);
        due_q.push_back(3);
        exp_q.push_back(model(held));   // Bubble from the cleared ID/EX
        repeat (2) @(posedge clock);
        #1;
        reset = 1'b0;
        for (int i = 0; i < 16; i++) begin
            make_instr(OP_RTYPE, funct_list[i], in);
            drive_instr(in, 1'b0, 1'b0);
        end
        for (int i = 1; i < 9; i++) begin
            make_instr(op_list[i], FN_ADD, in);
            drive_instr(in, 1'b0, 1'b0);
        end
        make_instr(OP_ORI, FN_ADD, in);
        drive_instr(in, 1'b0, 1'b0);
        make_instr(OP_XORI, FN_ADD, in);
        drive_instr(in, 1'b1, 1'b0);
        drive_instr(in, 1'b1, 1'b0);
        drive_instr(in, 1'b1, 1'b1);   // Held ORI must give way to the bubble
        drive_instr(in, 1'b0, 1'b1);
        for (int i = 0; i < N_RANDOM; i++) begin
            r = $random(seed);
            make_instr(op_list[r[15:8] % 9], funct_list[r[23:20]], in);
            drive_instr(in, r[2:0] == 3'd0, r[7:4] == 4'd0);
        end
        stall      = 1'b0;
        flush      = 1'b0;
        wait_count = 0;
        while (due_q.size() > 0 && wait_count < 10) begin
            @(posedge clock);
            wait_count++;
        end
        if (due_q.size() > 0) begin
            timeouts++;
            $display("timeout: %0d expected results never reached the outputs", due_q.size());
        end
        $display("errors: %0d mismatches, %0d property failures, %0d timeouts",
                 errors, dut_i.props_i.fail_count, timeouts);
        if (errors + timeouts + dut_i.props_i.fail_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
hdl/ex_pkg.sv
hdl/id_ex_reg.sv
hdl/alu_control.sv
hdl/alu.sv
hdl/ex_stage.sv
hdl/ex_mem_reg.sv
hdl/ex_pipe_top.sv
bench/ex_pipe_props.sv
bench/ex_pipe_tb.sv
